// ==== hw/ttl_bridge_config.svh ====
`ifndef TTL_BRIDGE_CONFIG_SVH
`define TTL_BRIDGE_CONFIG_SVH

// TTL side of the bridge, one byte wide
`define TTL_ADDR_WIDTH 16

`define TTL_DATA_WIDTH 8

// Master command port, single-beat words
`define MST_ADDR_WIDTH 32

`define MST_DATA_WIDTH 32

// The TTL byte rides in the low lane of a master word
// so the master data width must not be narrower than it

`endif

// ==== hw/ttl_bridge_pkg.sv ====
package ttl_bridge_pkg;

  `include "ttl_bridge_config.svh"

  typedef logic [`TTL_ADDR_WIDTH-1:0] ttlAddr_t;
  typedef logic [`TTL_DATA_WIDTH-1:0] ttlData_t;
  typedef logic [`MST_ADDR_WIDTH-1:0] mstAddr_t;
  typedef logic [`MST_DATA_WIDTH-1:0] mstData_t;

  // Sequencer states, grouped by address, read and write phases
  typedef enum logic [4:0] {
    Idle,
    AddrIntrReq,
    AddrIntrAck,
    AddrIntrPending,
    Dispatch,
    MstRead,
    ReadIntrReq,
    ReadIntrAck,
    ReadIntrPending,
    MstWrite,
    WriteIntrReq,
    WriteIntrAck,
    WriteIntrPending,
    Finish
  } seqState_t;

endpackage

// ==== hw/ttlBusFrontEnd.sv ====
`timescale 1ns/1ps

module ttlBusFrontEnd import ttl_bridge_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     nChipEnable,
  input  logic     nOutputEnable,
  input  logic     nWriteEnable,
  input  ttlAddr_t address,
  input  ttlData_t dataIn,
  input  ttlData_t readData,
  input  logic     readValid,
  output ttlAddr_t accessAddr,
  output ttlData_t accessData,
  output logic     readStrobe,
  output logic     writeStrobe,
  output logic     addrChanged,
  output ttlData_t dataOut,
  output logic     dataOutEnable
);

  logic [1:0] ceSync;
  logic [1:0] oeSync;
  logic [1:0] weSync;
  logic       oePrev;
  logic       wePrev;
  logic       firstAccess;
  logic       readActive;
  logic       readAccess;
  logic       readHit;
  logic       writeHit;

  // Edges are taken on the synchronized copies only
  assign readAccess = !ceSync[1] && !oeSync[1] && weSync[1];
  assign readHit    = readAccess && oePrev;
  assign writeHit   = !ceSync[1] && wePrev && !weSync[1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ceSync      <= 2'b11;
      oeSync      <= 2'b11;
      weSync      <= 2'b11;
      oePrev      <= 1'b1;
      wePrev      <= 1'b1;
      readStrobe  <= 1'b0;
      writeStrobe <= 1'b0;
      addrChanged <= 1'b0;
      firstAccess <= 1'b1;
      readActive  <= 1'b0;
    end else begin
      ceSync      <= {ceSync[0], nChipEnable};
      oeSync      <= {oeSync[0], nOutputEnable};
      weSync      <= {weSync[0], nWriteEnable};
      oePrev      <= oeSync[1];
      wePrev      <= weSync[1];
      readStrobe  <= readHit;
      writeStrobe <= writeHit;
      // First access after reset always counts as a new address
      addrChanged <= (readHit || writeHit) && (firstAccess || address != accessAddr);
      if (readHit || writeHit) begin
        firstAccess <= 1'b0;
      end
      // Armed by the strobe so a stale byte from the last read never shows
      if (readStrobe) begin
        readActive <= 1'b1;
      end else if (!readAccess) begin
        readActive <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (readHit || writeHit) begin
      accessAddr <= address;
      accessData <= dataIn;
    end
  end

  assign dataOut       = readData;
  assign dataOutEnable = readActive && readAccess && readValid;

endmodule

// ==== hw/bridgeSequencer.sv ====
`timescale 1ns/1ps

module bridgeSequencer import ttl_bridge_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  ttlAddr_t accessAddr,
  input  ttlData_t accessData,
  input  logic     readStrobe,
  input  logic     writeStrobe,
  input  logic     addrChanged,
  input  mstAddr_t mappedAddress,
  input  ttlAddr_t busAddressWriteReg,
  input  ttlData_t busDataWriteReg,
  input  logic     addrIntrEnable,
  input  logic     addrIntrStatus,
  input  logic     readIntrEnable,
  input  logic     readIntrStatus,
  input  logic     writeIntrEnable,
  input  logic     writeIntrStatus,
  input  logic     done,
  input  ttlData_t rdData,
  output logic     addrIntr,
  output logic     readIntr,
  output logic     writeIntr,
  output logic     rdStart,
  output logic     wrStart,
  output mstAddr_t cmdAddr,
  output mstData_t cmdData,
  output ttlData_t readData,
  output logic     readValid,
  output ttlAddr_t busAddressReadReg,
  output ttlData_t busDataReadReg
);

  seqState_t state;
  ttlAddr_t  busAddress;
  ttlData_t  busData;
  logic      isWrite;
  logic      accessStart;
  logic      launch;
  logic      launchWrite;
  ttlAddr_t  launchAddr;
  ttlData_t  launchData;

  assign accessStart = (state == Idle) && (readStrobe || writeStrobe);

  // From Idle the access goes out directly, after an address interrupt it
  // goes out of Dispatch with the overridden address
  always_comb begin
    launchAddr  = busAddress;
    launchData  = busData;
    launchWrite = isWrite;
    launch      = (state == Dispatch);
    if (state == Idle) begin
      launchAddr  = accessAddr;
      launchData  = accessData;
      launchWrite = writeStrobe;
      launch      = accessStart && !(addrIntrEnable && addrChanged);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= Idle;
      addrIntr  <= 1'b0;
      readIntr  <= 1'b0;
      writeIntr <= 1'b0;
      rdStart   <= 1'b0;
      wrStart   <= 1'b0;
      readValid <= 1'b0;
      isWrite   <= 1'b0;
    end else begin
      rdStart <= 1'b0;
      wrStart <= 1'b0;
      unique case (state)
        Idle, Dispatch: begin
          if (accessStart) begin
            isWrite   <= writeStrobe;
            readValid <= 1'b0;
          end
          if (launch) begin
            cmdAddr <= mappedAddress + mstAddr_t'(launchAddr);
            if (launchWrite && writeIntrEnable) begin
              state <= WriteIntrReq;
            end else if (launchWrite) begin
              wrStart <= 1'b1;
              cmdData <= mstData_t'(launchData);
              state   <= MstWrite;
            end else begin
              rdStart <= 1'b1;
              state   <= MstRead;
            end
          end else if (accessStart) begin
            state <= AddrIntrReq;
          end
        end
        AddrIntrReq: if (!addrIntrStatus) begin
          addrIntr <= 1'b1;
          state    <= AddrIntrAck;
        end
        AddrIntrAck: if (addrIntrStatus) begin
          addrIntr <= 1'b0;
          state    <= AddrIntrPending;
        end
        AddrIntrPending: if (!addrIntrStatus) begin
          state <= Dispatch;
        end
        MstRead: if (done) begin
          if (readIntrEnable) begin
            state <= ReadIntrReq;
          end else begin
            // Early hand-back keeps readValid one cycle behind done
            readValid <= 1'b1;
            state     <= Finish;
          end
        end
        ReadIntrReq: if (!readIntrStatus) begin
          readIntr <= 1'b1;
          state    <= ReadIntrAck;
        end
        ReadIntrAck: if (readIntrStatus) begin
          readIntr <= 1'b0;
          state    <= ReadIntrPending;
        end
        ReadIntrPending: if (!readIntrStatus) begin
          state <= Finish;
        end
        WriteIntrReq: if (!writeIntrStatus) begin
          writeIntr <= 1'b1;
          state     <= WriteIntrAck;
        end
        WriteIntrAck: if (writeIntrStatus) begin
          writeIntr <= 1'b0;
          state     <= WriteIntrPending;
        end
        WriteIntrPending: if (!writeIntrStatus) begin
          wrStart <= 1'b1;
          cmdData <= mstData_t'(busDataWriteReg);
          state   <= MstWrite;
        end
        MstWrite: if (done) begin
          state <= Finish;
        end
        Finish: begin
          readValid <= 1'b1;
          state     <= Idle;
        end
        default: state <= Idle;
      endcase
    end
  end

  // Bus address and data registers, visible to software
  always_ff @(posedge clk) begin
    if (accessStart) begin
      busAddress <= accessAddr;
      busData    <= accessData;
    end else if (state == AddrIntrPending && !addrIntrStatus) begin
      busAddress <= busAddressWriteReg;
    end else if (state == MstRead && done) begin
      busData <= rdData;
    end else if ((state == ReadIntrPending && !readIntrStatus) ||
                 (state == WriteIntrPending && !writeIntrStatus)) begin
      busData <= busDataWriteReg;
    end
    if (state == MstRead && done && !readIntrEnable) begin
      readData <= rdData;
    end else if (state == Finish) begin
      readData <= busData;
    end
  end

  assign busAddressReadReg = busAddress;
  assign busDataReadReg    = busData;

endmodule

// ==== hw/masterCommandPort.sv ====
`timescale 1ns/1ps

`include "ttl_bridge_config.svh"

module masterCommandPort import ttl_bridge_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     rdStart,
  input  logic     wrStart,
  input  mstAddr_t cmdAddr,
  input  mstData_t cmdData,
  input  logic     cmdAck,
  input  logic     cmplt,
  input  logic     error,
  input  mstData_t mstrdData,
  output logic     mstrdReq,
  output logic     mstwrReq,
  output mstAddr_t mstAddr,
  output mstData_t mstwrData,
  output logic     done,
  output ttlData_t rdData,
  output logic     mstError
);

  logic waitCmplt;
  logic acked;
  logic finish;

  assign acked  = (mstrdReq || mstwrReq) && cmdAck;
  // cmplt may come in the same cycle as cmdAck
  assign finish = cmplt && (waitCmplt || acked);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mstrdReq  <= 1'b0;
      mstwrReq  <= 1'b0;
      waitCmplt <= 1'b0;
      done      <= 1'b0;
      mstError  <= 1'b0;
    end else begin
      done <= finish;
      if (rdStart || wrStart) begin
        mstrdReq <= rdStart;
        mstwrReq <= wrStart;
      end else if (cmdAck) begin
        mstrdReq <= 1'b0;
        mstwrReq <= 1'b0;
      end
      if (acked && !cmplt) begin
        waitCmplt <= 1'b1;
      end else if (finish) begin
        waitCmplt <= 1'b0;
      end
      // Sticky until reset
      if (finish && error) begin
        mstError <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rdStart || wrStart) begin
      mstAddr   <= cmdAddr;
      mstwrData <= cmdData;
    end
    if (finish) begin
      rdData <= mstrdData[`TTL_DATA_WIDTH-1:0];
    end
  end

endmodule

// ==== hw/ttlMemoryBridge.sv ====
`timescale 1ns/1ps

module ttlMemoryBridge import ttl_bridge_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     nChipEnable,
  input  logic     nOutputEnable,
  input  logic     nWriteEnable,
  input  ttlAddr_t address,
  input  ttlData_t dataIn,
  input  mstAddr_t mappedAddress,
  input  ttlAddr_t busAddressWriteReg,
  input  ttlData_t busDataWriteReg,
  input  logic     addrIntrEnable,
  input  logic     addrIntrStatus,
  input  logic     readIntrEnable,
  input  logic     readIntrStatus,
  input  logic     writeIntrEnable,
  input  logic     writeIntrStatus,
  input  logic     cmdAck,
  input  logic     cmplt,
  input  logic     error,
  input  mstData_t mstrdData,
  output ttlData_t dataOut,
  output logic     dataOutEnable,
  output ttlAddr_t busAddressReadReg,
  output ttlData_t busDataReadReg,
  output logic     addrIntr,
  output logic     readIntr,
  output logic     writeIntr,
  output logic     mstrdReq,
  output logic     mstwrReq,
  output mstAddr_t mstAddr,
  output mstData_t mstwrData,
  output logic     mstError
);

  ttlAddr_t accessAddr;
  ttlData_t accessData;
  logic     readStrobe;
  logic     writeStrobe;
  logic     addrChanged;
  ttlData_t readData;
  logic     readValid;
  logic     rdStart;
  logic     wrStart;
  mstAddr_t cmdAddr;
  mstData_t cmdData;
  logic     done;
  ttlData_t rdData;

  ttlBusFrontEnd frontEnd (
    .clk           (clk),
    .rst_n         (rst_n),
    .nChipEnable   (nChipEnable),
    .nOutputEnable (nOutputEnable),
    .nWriteEnable  (nWriteEnable),
    .address       (address),
    .dataIn        (dataIn),
    .readData      (readData),
    .readValid     (readValid),
    .accessAddr    (accessAddr),
    .accessData    (accessData),
    .readStrobe    (readStrobe),
    .writeStrobe   (writeStrobe),
    .addrChanged   (addrChanged),
    .dataOut       (dataOut),
    .dataOutEnable (dataOutEnable)
  );

  bridgeSequencer sequencer (
    .clk                (clk),
    .rst_n              (rst_n),
    .accessAddr         (accessAddr),
    .accessData         (accessData),
    .readStrobe         (readStrobe),
    .writeStrobe        (writeStrobe),
    .addrChanged        (addrChanged),
    .mappedAddress      (mappedAddress),
    .busAddressWriteReg (busAddressWriteReg),
    .busDataWriteReg    (busDataWriteReg),
    .addrIntrEnable     (addrIntrEnable),
    .addrIntrStatus     (addrIntrStatus),
    .readIntrEnable     (readIntrEnable),
    .readIntrStatus     (readIntrStatus),
    .writeIntrEnable    (writeIntrEnable),
    .writeIntrStatus    (writeIntrStatus),
    .done               (done),
    .rdData             (rdData),
    .addrIntr           (addrIntr),
    .readIntr           (readIntr),
    .writeIntr          (writeIntr),
    .rdStart            (rdStart),
    .wrStart            (wrStart),
    .cmdAddr            (cmdAddr),
    .cmdData            (cmdData),
    .readData           (readData),
    .readValid          (readValid),
    .busAddressReadReg  (busAddressReadReg),
    .busDataReadReg     (busDataReadReg)
  );

  masterCommandPort commandPort (
    .clk       (clk),
    .rst_n     (rst_n),
    .rdStart   (rdStart),
    .wrStart   (wrStart),
    .cmdAddr   (cmdAddr),
    .cmdData   (cmdData),
    .cmdAck    (cmdAck),
    .cmplt     (cmplt),
    .error     (error),
    .mstrdData (mstrdData),
    .mstrdReq  (mstrdReq),
    .mstwrReq  (mstwrReq),
    .mstAddr   (mstAddr),
    .mstwrData (mstwrData),
    .done      (done),
    .rdData    (rdData),
    .mstError  (mstError)
  );

endmodule

// ==== testbench/ttlMemoryBridge_sva.sv ====
`timescale 1ns/1ps

module ttlMemoryBridge_sva (
  input logic       clk,
  input logic       rst_n,
  input logic       rdReq,
  input logic       wrReq,
  input logic       ack,
  input logic [2:0] intrVec
);

  // A request holds until the slave takes it
  rdHeld: assert property (@(posedge clk) disable iff (!rst_n) (rdReq && !ack) |=> rdReq)
    else $error("mstrdReq dropped before cmdAck");

  wrHeld: assert property (@(posedge clk) disable iff (!rst_n) (wrReq && !ack) |=> wrReq)
    else $error("mstwrReq dropped before cmdAck");

  reqExclusive: assert property (@(posedge clk) disable iff (!rst_n) !(rdReq && wrReq))
    else $error("mstrdReq and mstwrReq high together");

  // Only one software interrupt at a time
  intrOneHot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(intrVec))
    else $error("More than one interrupt output high");

endmodule

bind masterCommandPort ttlMemoryBridge_sva requestChecks (
  .clk     (clk),
  .rst_n   (rst_n),
  .rdReq   (mstrdReq),
  .wrReq   (mstwrReq),
  .ack     (cmdAck),
  .intrVec (3'b000)
);

bind bridgeSequencer ttlMemoryBridge_sva intrChecks (
  .clk     (clk),
  .rst_n   (rst_n),
  .rdReq   (1'b0),
  .wrReq   (1'b0),
  .ack     (1'b0),
  .intrVec ({addrIntr, readIntr, writeIntr})
);

// ==== testbench/ttlMemoryBridge_tb.sv ====
`timescale 1ns/1ps

// Software side of one interrupt, raises status two cycles after intr
// and lowers it two cycles after intr falls
module intrResponder (
  input  logic clk,
  input  logic intr,
  output logic status
);

  initial begin
    status = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (intr) begin
        repeat (2) @(posedge clk);
        #1;
        status = 1'b1;
        while (intr) begin
          @(posedge clk);
          #1;
        end
        repeat (2) @(posedge clk);
        #1;
        status = 1'b0;
      end
    end
  end

endmodule

module ttlMemoryBridge_tb import ttl_bridge_pkg::*; ();

  localparam int NumEntries = 8;
  localparam int TimeoutCycles = 16 + NumEntries * 60;
  localparam mstAddr_t MappedBase = 32'h8001_0000;
  localparam mstData_t ReadPattern = 32'h5a5a_c3c3;

  typedef struct packed {
    logic     isWrite;
    ttlAddr_t addr;
    ttlData_t wrByte;
    logic     addrIntrOn;
    logic     readIntrOn;
    logic     writeIntrOn;
    ttlAddr_t ovrAddr;
    ttlData_t ovrByte;
    logic     injectError;
  } stimEntry_t;

  logic     clk;
  logic     rst_n;
  logic     nChipEnable, nOutputEnable, nWriteEnable;
  ttlAddr_t address;
  ttlData_t dataIn;
  mstAddr_t mappedAddress;
  ttlAddr_t busAddressWriteReg;
  ttlData_t busDataWriteReg;
  logic     addrIntrEnable, readIntrEnable, writeIntrEnable;
  logic     addrIntrStatus, readIntrStatus, writeIntrStatus;
  logic     cmdAck, cmplt, error;
  mstData_t mstrdData;
  ttlData_t dataOut;
  logic     dataOutEnable;
  ttlAddr_t busAddressReadReg;
  ttlData_t busDataReadReg;
  logic     addrIntr, readIntr, writeIntr;
  logic     mstrdReq, mstwrReq;
  mstAddr_t mstAddr;
  mstData_t mstwrData;
  logic     mstError;

  stimEntry_t  stimTable [NumEntries];
  mstData_t    writeLog [mstAddr_t];
  logic [31:0] rngState;
  logic        errInject;
  int          errorCount;
  int          checkCount;
  int          cycleCount;

  ttlMemoryBridge DUT (.*);

  intrResponder addrSw  (.clk(clk), .intr(addrIntr),  .status(addrIntrStatus));
  intrResponder readSw  (.clk(clk), .intr(readIntr),  .status(readIntrStatus));
  intrResponder writeSw (.clk(clk), .intr(writeIntr), .status(writeIntrStatus));

  function automatic logic [31:0] nextRandom(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic checkAddr(input mstAddr_t got, input mstAddr_t exp, input string what);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkBusAddr(input ttlAddr_t got, input ttlAddr_t exp, input string what);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkData(input ttlData_t got, input ttlData_t exp, input string what);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkWord(input mstData_t got, input mstData_t exp, input string what);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkFlag(input logic got, input logic exp, input string what);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Columns: write, address, write byte, addr/read/write intr enables,
  // override address, override byte, error answer
  initial begin : stimulusTable
    stimTable[0] = '{1'b1, 16'h0010, 8'ha5, 1'b0, 1'b0, 1'b0, 16'h0000, 8'h00, 1'b0};
    stimTable[1] = '{1'b0, 16'h0010, 8'h00, 1'b0, 1'b0, 1'b0, 16'h0000, 8'h00, 1'b0};
    stimTable[2] = '{1'b0, 16'h1234, 8'h00, 1'b1, 1'b0, 1'b0, 16'h0200, 8'h00, 1'b0};
    stimTable[3] = '{1'b0, 16'h1234, 8'h00, 1'b1, 1'b0, 1'b0, 16'h0300, 8'h00, 1'b0};
    stimTable[4] = '{1'b0, 16'h0456, 8'h00, 1'b0, 1'b1, 1'b0, 16'h0000, 8'h3c, 1'b0};
    stimTable[5] = '{1'b1, 16'h0457, 8'h81, 1'b0, 1'b0, 1'b1, 16'h0000, 8'he7, 1'b0};
    stimTable[6] = '{1'b1, 16'h0800, 8'h42, 1'b1, 1'b0, 1'b1, 16'h0ff0, 8'h99, 1'b0};
    stimTable[7] = '{1'b0, 16'h0020, 8'h00, 1'b0, 1'b0, 1'b0, 16'h0000, 8'h00, 1'b1};
  end

  // Slave model, acknowledges after 0 to 3 cycles and completes
  // with the acknowledge or one cycle behind it
  initial begin : memoryModel
    int delay;
    rngState  = 32'h9f70_ee5f;
    cmdAck    = 1'b0;
    cmplt     = 1'b0;
    error     = 1'b0;
    mstrdData = '0;
    forever begin
      @(posedge clk);
      #1;
      if (rst_n && (mstrdReq || mstwrReq)) begin
        rngState = nextRandom(rngState);
        delay = int'(rngState[1:0]);
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        if (mstwrReq) begin
          writeLog[mstAddr] = mstwrData;
        end
        cmdAck = 1'b1;
        if (rngState[2]) begin
          @(posedge clk);
          #1;
          cmdAck = 1'b0;
        end
        mstrdData = mstAddr ^ ReadPattern;
        error     = errInject;
        cmplt     = 1'b1;
        @(posedge clk);
        #1;
        cmdAck = 1'b0;
        cmplt  = 1'b0;
        error  = 1'b0;
      end
    end
  end

  initial begin : watchdog
    cycleCount = 0;
    while (cycleCount < TimeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: an access did not complete within %0d cycles", TimeoutCycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : mainFlow
    stimEntry_t e;
    mstAddr_t   expAddr;
    mstAddr_t   seenAddr;
    mstData_t   expWord;
    mstData_t   seenWord;
    ttlData_t   expByte;
    ttlData_t   pendExp;
    ttlData_t   pendByte;
    ttlAddr_t   pendAddr;
    ttlAddr_t   prevAddr;
    logic       firstAccess;
    logic       expAddrIntr;
    logic       errSeen;
    logic       sawAddrIntr;
    logic       sawReq;
    logic       finished;
    errorCount         = 0;
    checkCount         = 0;
    rst_n              = 1'b0;
    nChipEnable        = 1'b1;
    nOutputEnable      = 1'b1;
    nWriteEnable       = 1'b1;
    address            = '0;
    dataIn             = '0;
    mappedAddress      = MappedBase;
    busAddressWriteReg = '0;
    busDataWriteReg    = '0;
    addrIntrEnable     = 1'b0;
    readIntrEnable     = 1'b0;
    writeIntrEnable    = 1'b0;
    errInject          = 1'b0;
    seenAddr           = '0;
    seenWord           = '0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    checkFlag(mstrdReq, 1'b0, "mstrdReq after reset");
    checkFlag(mstwrReq, 1'b0, "mstwrReq after reset");
    checkFlag(addrIntr, 1'b0, "addrIntr after reset");
    checkFlag(readIntr, 1'b0, "readIntr after reset");
    checkFlag(writeIntr, 1'b0, "writeIntr after reset");
    checkFlag(dataOutEnable, 1'b0, "dataOutEnable after reset");
    checkFlag(mstError, 1'b0, "mstError after reset");
    firstAccess = 1'b1;
    prevAddr    = '0;
    errSeen     = 1'b0;

    for (int i = 0; i < NumEntries; i++) begin
      e = stimTable[i];
      // Address interrupt only on the first access or a new TTL address
      expAddrIntr = e.addrIntrOn && (firstAccess || e.addr != prevAddr);
      expAddr     = MappedBase + mstAddr_t'(expAddrIntr ? e.ovrAddr : e.addr);
      errSeen     = errSeen | e.injectError;

      address            = e.addr;
      dataIn             = e.wrByte;
      busAddressWriteReg = e.ovrAddr;
      busDataWriteReg    = e.ovrByte;
      addrIntrEnable     = e.addrIntrOn;
      readIntrEnable     = e.readIntrOn;
      writeIntrEnable    = e.writeIntrOn;
      errInject          = e.injectError;
      nChipEnable        = 1'b0;
      @(posedge clk);
      #1;
      if (e.isWrite) begin
        nWriteEnable = 1'b0;
      end else begin
        nOutputEnable = 1'b0;
      end

      sawAddrIntr = 1'b0;
      sawReq      = 1'b0;
      finished    = 1'b0;
      pendByte    = '0;
      pendAddr    = '0;
      while (!finished) begin
        @(posedge clk);
        #1;
        if (addrIntr) begin
          sawAddrIntr = 1'b1;
          pendAddr    = busAddressReadReg;
        end
        if (readIntr || writeIntr) begin
          pendByte = busDataReadReg;
        end
        if (mstrdReq || mstwrReq) begin
          sawReq   = 1'b1;
          seenAddr = mstAddr;
          seenWord = mstwrData;
        end
        // A write ends when its request falls, a read when data is driven
        finished = e.isWrite ? (sawReq && !mstwrReq) : dataOutEnable;
      end

      checkFlag(sawAddrIntr, expAddrIntr, "addrIntr raised");
      if (expAddrIntr) begin
        checkBusAddr(pendAddr, e.addr, "busAddressReadReg while pending");
      end
      checkAddr(seenAddr, expAddr, "mstAddr");
      if (e.isWrite) begin
        expByte = e.writeIntrOn ? e.ovrByte : e.wrByte;
        expWord = mstData_t'(expByte);
        pendExp = e.wrByte;
        checkWord(seenWord, expWord, "mstwrData");
        checkWord(writeLog[expAddr], expWord, "write seen by memory");
      end else begin
        expWord = expAddr ^ ReadPattern;
        pendExp = expWord[7:0];
        expByte = e.readIntrOn ? e.ovrByte : pendExp;
        checkData(dataOut, expByte, "dataOut");
      end
      if ((e.isWrite && e.writeIntrOn) || (!e.isWrite && e.readIntrOn)) begin
        checkData(pendByte, pendExp, "busDataReadReg while pending");
      end
      checkFlag(mstError, errSeen, "mstError");

      nChipEnable   = 1'b1;
      nOutputEnable = 1'b1;
      nWriteEnable  = 1'b1;
      prevAddr      = e.addr;
      firstAccess   = 1'b0;
      repeat (4) @(posedge clk);
      #1;
    end

    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+hw
hw/ttl_bridge_pkg.sv
hw/ttlBusFrontEnd.sv
hw/bridgeSequencer.sv
hw/masterCommandPort.sv
hw/ttlMemoryBridge.sv
testbench/ttlMemoryBridge_sva.sv
testbench/ttlMemoryBridge_tb.sv

// ==== Makefile ====
SIM := obj_dir/VttlMemoryBridge_tb
SOURCES := src.f $(wildcard hw/*.sv hw/*.svh testbench/*.sv)

.PHONY: run clean

run: $(SIM)
	$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -qF "*** TEST FAILED ***" sim.log || ! grep -qF "*** TEST PASSED ***" sim.log; then \
	  echo "Simulation reported failure"; exit 1; fi

$(SIM): $(SOURCES)
	verilator --binary --timing --assert -j 0 --top-module ttlMemoryBridge_tb \
	  -f src.f -o VttlMemoryBridge_tb

clean:
	rm -rf obj_dir sim.log
